// File: hdl/aim_pkg.sv
package aim_pkg;

    // ======================================================================
    // plain vector types
    // ======================================================================

    typedef logic [7:0]  cam_byte_t;
    typedef logic [15:0] pix565_t;
    typedef logic [7:0]  chan8_t;
    typedef logic [11:0] line_cnt_t;

    // ======================================================================
    // bundles passed between the pixel path stages
    // ======================================================================

    // one camera after byte assembly, all fields in the clk domain.
    typedef struct packed {
        logic    frame;
        logic    frame_start;
        logic    pix_valid;
        logic    line_end;
        pix565_t pixel;
    } cam_stream_t;

    // a matched pair of pixels, one from each camera.
    typedef struct packed {
        logic    valid;
        pix565_t pixel_1;
        pix565_t pixel_2;
    } pix_pair_t;

    typedef struct packed {
        logic   de;
        logic   hsync;
        logic   vsync;
        chan8_t r;
        chan8_t g;
        chan8_t b;
    } hdmi_px_t;

    typedef enum logic [1:0] {
        HS_IDLE,
        HS_WAIT,
        HS_PULSE
    } hs_state_t;

endpackage : aim_pkg

// File: hdl/cam_pixel_decode.sv
module cam_pixel_decode
    import aim_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        vsync,
    input  logic        href,
    input  logic        byte_en,
    input  cam_byte_t   data,
    output cam_stream_t stream
);

    logic      href_q;
    logic      phase;
    cam_byte_t hi_byte;

    logic      frame_q;
    logic      frame_start_q;
    logic      pix_valid_q;
    logic      line_end_q;
    pix565_t   pixel_q;

    logic      byte_strobe;
    logic      href_fall;

    assign byte_strobe = href & byte_en;
    assign href_fall   = href_q & ~href;

    // ======================================================================
    // control state
    // ======================================================================

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            href_q        <= 1'b0;
            phase         <= 1'b0;
            frame_q       <= 1'b0;
            frame_start_q <= 1'b0;
            pix_valid_q   <= 1'b0;
            line_end_q    <= 1'b0;
        end else begin
            href_q        <= href;
            frame_q       <= vsync;
            frame_start_q <= vsync & ~frame_q;
            line_end_q    <= href_fall;
            pix_valid_q   <= byte_strobe & phase;

            // a line that ends on an odd byte leaves phase set, so it is
            // cleared here and the dangling byte is lost.
            if (href_fall) begin
                phase <= 1'b0;
            end else if (byte_strobe) begin
                phase <= ~phase;
            end
        end
    end

    // ======================================================================
    // byte assembly
    // ======================================================================

    always_ff @(posedge clk) begin
        if (byte_strobe && !phase) begin
            hi_byte <= data;
        end
        if (byte_strobe && phase) begin
            pixel_q <= {hi_byte, data};
        end
    end

    always_comb begin
        stream.frame       = frame_q;
        stream.frame_start = frame_start_q;
        stream.pix_valid   = pix_valid_q;
        stream.line_end    = line_end_q;
        stream.pixel       = pixel_q;
    end

endmodule : cam_pixel_decode

// File: hdl/pixel_combine.sv
module pixel_combine
    import aim_pkg::*;
#(
    parameter int FIFO_DEPTH = 8
) (
    input  logic        clk,
    input  logic        rst_n,
    input  cam_stream_t stream_1,
    input  cam_stream_t stream_2,
    output pix_pair_t   pair,
    output logic        comb_err
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);

    cam_stream_t      streams   [2];
    pix565_t          mem       [2][FIFO_DEPTH];
    logic [PTR_W:0]   wr_ptr    [2];
    logic [PTR_W:0]   rd_ptr;
    line_cnt_t        line_cnt  [2];
    logic [1:0]       line_done;
    logic [1:0]       empty;
    logic [1:0]       full;
    logic [1:0]       push;
    logic [1:0]       overflow;

    logic             flush;
    logic             pop;
    logic             line_cmp;

    logic             pair_valid;
    pix565_t          pair_pix_1;
    pix565_t          pair_pix_2;

    assign streams[0] = stream_1;
    assign streams[1] = stream_2;

    // a new frame on cam1 restarts the pairing from scratch.
    assign flush    = stream_1.frame_start;
    assign pop      = ~empty[0] & ~empty[1] & ~flush;
    assign line_cmp = line_done[0] & line_done[1];

    // ======================================================================
    // per-camera buffer and line counter
    // ======================================================================

    for (genvar i = 0; i < 2; i++) begin : g_cam
        assign empty[i]    = (wr_ptr[i] == rd_ptr);
        assign full[i]     = ((wr_ptr[i] ^ rd_ptr) == {1'b1, {PTR_W{1'b0}}});
        assign push[i]     = streams[i].pix_valid & ~full[i] & ~flush;
        assign overflow[i] = streams[i].pix_valid & full[i] & ~flush;

        always_ff @(posedge clk) begin
            if (!rst_n) begin
                wr_ptr[i] <= '0;
            end else if (flush) begin
                wr_ptr[i] <= '0;
            end else if (push[i]) begin
                wr_ptr[i] <= wr_ptr[i] + 1'b1;
            end
        end

        always_ff @(posedge clk) begin
            if (push[i]) begin
                mem[i][wr_ptr[i][PTR_W-1:0]] <= streams[i].pixel;
            end
        end

        // pixels are counted as they arrive, whether or not they fit.
        always_ff @(posedge clk) begin
            if (!rst_n) begin
                line_cnt[i]  <= '0;
                line_done[i] <= 1'b0;
            end else if (flush) begin
                line_cnt[i]  <= '0;
                line_done[i] <= 1'b0;
            end else if (line_cmp) begin
                line_cnt[i]  <= streams[i].pix_valid ? line_cnt_t'(1) : '0;
                line_done[i] <= streams[i].line_end;
            end else begin
                if (streams[i].pix_valid) begin
                    line_cnt[i] <= line_cnt[i] + 1'b1;
                end
                if (streams[i].line_end) begin
                    line_done[i] <= 1'b1;
                end
            end
        end
    end

    // ======================================================================
    // pair release and error flag
    // ======================================================================

    // both buffers pop together, so one read pointer serves both.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_ptr     <= '0;
            pair_valid <= 1'b0;
            comb_err   <= 1'b0;
        end else begin
            pair_valid <= pop;
            if (flush) begin
                rd_ptr <= '0;
            end else if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end

            if (flush) begin
                comb_err <= 1'b0;
            end else if ((|overflow) || (line_cmp && line_cnt[0] != line_cnt[1])) begin
                comb_err <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            pair_pix_1 <= mem[0][rd_ptr[PTR_W-1:0]];
            pair_pix_2 <= mem[1][rd_ptr[PTR_W-1:0]];
        end
    end

    always_comb begin
        pair.valid   = pair_valid;
        pair.pixel_1 = pair_pix_1;
        pair.pixel_2 = pair_pix_2;
    end

endmodule : pixel_combine

// File: hdl/hdmi_out.sv
module hdmi_out
    import aim_pkg::*;
#(
    parameter int HS_AFTER = 5,
    parameter int HS_HOLD  = 5
) (
    input  logic      clk,
    input  logic      rst_n,
    input  pix_pair_t pair,
    input  logic      vsync,
    output hdmi_px_t  hdmi,
    output pix565_t   stereo_pix
);

    localparam int HS_MAX = (HS_AFTER > HS_HOLD) ? HS_AFTER : HS_HOLD;
    localparam int CNT_W  = $clog2(HS_MAX + 1);

    logic       de_q;
    logic       vsync_q;
    chan8_t     r_q;
    chan8_t     g_q;
    chan8_t     b_q;
    pix565_t    stereo_q;

    hs_state_t  hs_state;
    logic [CNT_W-1:0] hs_cnt;
    logic       de_falling;

    // ======================================================================
    // pixel and sync registers
    // ======================================================================

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            de_q    <= 1'b0;
            vsync_q <= 1'b0;
        end else begin
            de_q    <= pair.valid;
            vsync_q <= vsync;
        end
    end

    // the 565 fields land in the top bits of each channel.
    always_ff @(posedge clk) begin
        r_q      <= {pair.pixel_1[15:11], 3'b000};
        g_q      <= {pair.pixel_1[10:5], 2'b00};
        b_q      <= {pair.pixel_1[4:0], 3'b000};
        stereo_q <= pair.pixel_2;
    end

    // ======================================================================
    // hsync generation
    // ======================================================================

    // de drops on the next edge when it is high now and the pair is idle.
    assign de_falling = de_q & ~pair.valid;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hs_state <= HS_IDLE;
            hs_cnt   <= '0;
        end else begin
            case (hs_state)
                HS_IDLE: begin
                    if (de_falling) begin
                        hs_state <= HS_WAIT;
                        hs_cnt   <= CNT_W'(HS_AFTER - 1);
                    end
                end
                HS_WAIT: begin
                    if (hs_cnt == '0) begin
                        hs_state <= HS_PULSE;
                        hs_cnt   <= CNT_W'(HS_HOLD - 1);
                    end else begin
                        hs_cnt <= hs_cnt - 1'b1;
                    end
                end
                HS_PULSE: begin
                    if (hs_cnt == '0) begin
                        hs_state <= HS_IDLE;
                    end else begin
                        hs_cnt <= hs_cnt - 1'b1;
                    end
                end
                default: hs_state <= HS_IDLE;
            endcase
        end
    end

    always_comb begin
        hdmi.de    = de_q;
        hdmi.hsync = (hs_state == HS_PULSE);
        hdmi.vsync = vsync_q;
        hdmi.r     = r_q;
        hdmi.g     = g_q;
        hdmi.b     = b_q;
    end

    assign stereo_pix = stereo_q;

endmodule : hdmi_out

// File: hdl/frame_tick.sv
module frame_tick #(
    parameter int TICK_PIXELS = 1280
) (
    input  logic clk,
    input  logic rst_n,
    input  logic trig,
    output logic tick
);

    localparam int CNT_W = $clog2(TICK_PIXELS + 1);

    logic [CNT_W-1:0] cnt;
    logic             last;

    assign last = (cnt == CNT_W'(TICK_PIXELS - 1));

    // the tick follows the trigger that completes the count, and counting
    // starts over from zero.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cnt  <= '0;
            tick <= 1'b0;
        end else begin
            tick <= trig & last;
            if (trig) begin
                if (last) begin
                    cnt <= '0;
                end else begin
                    cnt <= cnt + 1'b1;
                end
            end
        end
    end

endmodule : frame_tick

// File: hdl/aim_bot.sv
module aim_bot
    import aim_pkg::*;
#(
    parameter int FIFO_DEPTH  = 8,
    parameter int HS_AFTER    = 5,
    parameter int HS_HOLD     = 5,
    parameter int TICK_PIXELS = 1280
) (
    input  logic      clk,
    input  logic      rst_n,

    input  logic      cam1_vsync,
    input  logic      cam1_href,
    input  logic      cam1_byte_en,
    input  cam_byte_t cam1_data,

    input  logic      cam2_vsync,
    input  logic      cam2_href,
    input  logic      cam2_byte_en,
    input  cam_byte_t cam2_data,

    output hdmi_px_t  hdmi,
    output pix565_t   stereo_pix,
    output logic      comb_err,
    output logic      buf_tick
);

    cam_stream_t cam1_stream;
    cam_stream_t cam2_stream;
    pix_pair_t   comb_pair;

    cam_pixel_decode u_cam1_decode (
        .clk     (clk),
        .rst_n   (rst_n),
        .vsync   (cam1_vsync),
        .href    (cam1_href),
        .byte_en (cam1_byte_en),
        .data    (cam1_data),
        .stream  (cam1_stream)
    );

    cam_pixel_decode u_cam2_decode (
        .clk     (clk),
        .rst_n   (rst_n),
        .vsync   (cam2_vsync),
        .href    (cam2_href),
        .byte_en (cam2_byte_en),
        .data    (cam2_data),
        .stream  (cam2_stream)
    );

    pixel_combine #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_pixel_combine (
        .clk      (clk),
        .rst_n    (rst_n),
        .stream_1 (cam1_stream),
        .stream_2 (cam2_stream),
        .pair     (comb_pair),
        .comb_err (comb_err)
    );

    // output timing follows cam1's frame level.
    hdmi_out #(
        .HS_AFTER (HS_AFTER),
        .HS_HOLD  (HS_HOLD)
    ) u_hdmi_out (
        .clk        (clk),
        .rst_n      (rst_n),
        .pair       (comb_pair),
        .vsync      (cam1_stream.frame),
        .hdmi       (hdmi),
        .stereo_pix (stereo_pix)
    );

    frame_tick #(
        .TICK_PIXELS (TICK_PIXELS)
    ) u_buf_tick (
        .clk   (clk),
        .rst_n (rst_n),
        .trig  (comb_pair.valid),
        .tick  (buf_tick)
    );

endmodule : aim_bot

// File: dv/aim_bot_assert.sv
module aim_bot_assert
    import aim_pkg::*;
(
    input logic      clk,
    input logic      rst_n,
    input hs_state_t hs_state,
    input logic      hsync,
    input logic [1:0] empty,
    input logic      pair_valid,
    input logic      comb_err,
    input logic      frame_start
);

    a_hsync_idle_low : assert property (@(posedge clk) disable iff (!rst_n)
        (hs_state == HS_IDLE) |-> !hsync)
        else $error("hsync high while the hsync FSM is idle");

    // a pair only leaves when both buffers held a pixel one cycle before.
    a_pair_needs_data : assert property (@(posedge clk) disable iff (!rst_n)
        pair_valid |-> $past(!empty[0] && !empty[1]))
        else $error("pair released without data in both buffers");

    a_err_clear_cause : assert property (@(posedge clk) disable iff (!rst_n)
        $fell(comb_err) |-> ($past(frame_start) || !$past(rst_n)))
        else $error("comb_err cleared without a cam1 frame start");

endmodule : aim_bot_assert

bind pixel_combine aim_bot_assert u_comb_assert (
    .clk         (clk),
    .rst_n       (rst_n),
    .hs_state    (HS_IDLE),
    .hsync       (1'b0),
    .empty       (empty),
    .pair_valid  (pair.valid),
    .comb_err    (comb_err),
    .frame_start (stream_1.frame_start)
);

bind hdmi_out aim_bot_assert u_hs_assert (
    .clk         (clk),
    .rst_n       (rst_n),
    .hs_state    (hs_state),
    .hsync       (hdmi.hsync),
    .empty       (2'b00),
    .pair_valid  (1'b0),
    .comb_err    (1'b0),
    .frame_start (1'b0)
);

// File: dv/aim_bot_tb.sv
module aim_bot_tb
    import aim_pkg::*;
;

    localparam int TICK_PIXELS  = 16;
    localparam int HS_AFTER     = 5;
    localparam int HS_HOLD      = 5;
    localparam int RST_CYCLES   = 10;
    localparam int LINE_PIX     = 10;
    localparam int LINE_GAP     = 30;
    localparam int NUM_LINES    = 9;
    localparam int FRAME_CYCLES = 20;
    localparam int LINE_CYCLES  = 2 * LINE_PIX + 4 + LINE_GAP + 2;
    localparam int STIM_CYCLES  = RST_CYCLES + 5 + 2 * FRAME_CYCLES
                                + NUM_LINES * LINE_CYCLES + 10;
    localparam int CYCLE_LIMIT  = 2 * STIM_CYCLES;
    // the short line shows one pair fewer than the others.
    localparam int NUM_PAIRS    = NUM_LINES * LINE_PIX - 1;
    localparam logic [31:0] LFSR_SEED = 32'h460d_ace9;
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

    logic      clk = 1'b0;
    logic      rst_n;
    logic      cam1_vsync;
    logic      cam1_href;
    logic      cam1_byte_en;
    cam_byte_t cam1_data;
    logic      cam2_vsync;
    logic      cam2_href;
    logic      cam2_byte_en;
    cam_byte_t cam2_data;
    hdmi_px_t  hdmi;
    pix565_t   stereo_pix;
    logic      comb_err;
    logic      buf_tick;

    logic [31:0] lfsr_state;
    pix565_t     exp_q1[$];
    pix565_t     exp_q2[$];
    int          cycle_cnt;
    int          de_count;
    int          tick_count;
    int          hs_pulses;
    int          hs_age;
    int          since_reset;
    logic        de_prev;
    logic        hs_prev;
    logic [1:0]  vs_hist;

    aim_bot #(
        .TICK_PIXELS (TICK_PIXELS)
    ) DUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .cam1_vsync   (cam1_vsync),
        .cam1_href    (cam1_href),
        .cam1_byte_en (cam1_byte_en),
        .cam1_data    (cam1_data),
        .cam2_vsync   (cam2_vsync),
        .cam2_href    (cam2_href),
        .cam2_byte_en (cam2_byte_en),
        .cam2_data    (cam2_data),
        .hdmi         (hdmi),
        .stereo_pix   (stereo_pix),
        .comb_err     (comb_err),
        .buf_tick     (buf_tick)
    );

    always #20 clk = ~clk;

    // ======================================================================
    // reference model and compare tasks
    // ======================================================================

    // each 565 field sits at the top of its channel, padded with zeros.
    function automatic logic [23:0] expand_565(input pix565_t p);
        return {p[15:11], 3'b000, p[10:5], 2'b00, p[4:0], 3'b000};
    endfunction

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [15:0] val);
        val = '0;
        for (int k = 0; k < n; k++) begin
            lfsr_state = lfsr_next(lfsr_state);
            val = {val[14:0], lfsr_state[0]};
        end
    endtask

    task automatic stop_on_failure();
        $display("SOME TESTS FAILED");
        $fatal(1, "stopped at the first failure");
    endtask

    task automatic check_chan(input string what, input chan8_t got, input chan8_t exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s got %h, expected %h", $time, what, got, exp);
            stop_on_failure();
        end
    endtask

    task automatic check_pix(input string what, input pix565_t got, input pix565_t exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s got %h, expected %h", $time, what, got, exp);
            stop_on_failure();
        end
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s got %b, expected %b", $time, what, got, exp);
            stop_on_failure();
        end
    endtask

    // ======================================================================
    // output checker
    // ======================================================================

    always @(negedge clk) begin
        logic [23:0] rgb;
        pix565_t     p1;
        pix565_t     p2;
        logic        exp_tick;
        if (!rst_n) begin
            check_bit("de in reset", hdmi.de, 1'b0);
            check_bit("hsync in reset", hdmi.hsync, 1'b0);
            check_bit("vsync in reset", hdmi.vsync, 1'b0);
            check_bit("comb_err in reset", comb_err, 1'b0);
            check_bit("buf_tick in reset", buf_tick, 1'b0);
            since_reset = 0;
            hs_age = -1;
            de_prev = 1'b0;
        end else begin
            since_reset++;
            if (since_reset < 4) begin
                check_bit("comb_err after reset", comb_err, 1'b0);
            end

            // hsync starts HS_AFTER cycles after a fall of de seen while idle.
            if (hs_age >= 0) begin
                hs_age++;
                if (hs_age == HS_AFTER + HS_HOLD) begin
                    hs_age = -1;
                end
            end else if (de_prev && !hdmi.de) begin
                hs_age = 0;
            end
            check_bit("hsync", hdmi.hsync, hs_age >= HS_AFTER);
            if (hdmi.hsync && !hs_prev) begin
                hs_pulses++;
            end
            check_bit("vsync", hdmi.vsync, vs_hist[1]);

            exp_tick = 1'b0;
            if (hdmi.de) begin
                if (exp_q1.size() == 0 || exp_q2.size() == 0) begin
                    $display("A pixel pair was shown at %0t but none was expected.", $time);
                    stop_on_failure();
                end else begin
                    p1 = exp_q1.pop_front();
                    p2 = exp_q2.pop_front();
                    rgb = expand_565(p1);
                    check_chan("hdmi.r", hdmi.r, rgb[23:16]);
                    check_chan("hdmi.g", hdmi.g, rgb[15:8]);
                    check_chan("hdmi.b", hdmi.b, rgb[7:0]);
                    check_pix("stereo_pix", stereo_pix, p2);
                    de_count++;
                    exp_tick = (de_count % TICK_PIXELS) == 0;
                end
            end
            check_bit("buf_tick", buf_tick, exp_tick);
            if (buf_tick) begin
                tick_count++;
            end
            de_prev = hdmi.de;
        end
        hs_prev = hdmi.hsync;
        vs_hist = {vs_hist[0], cam1_vsync};
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles.", CYCLE_LIMIT);
            stop_on_failure();
        end
    end

    // ======================================================================
    // stimulus
    // ======================================================================

    task automatic start_frame();
        @(posedge clk);
        cam1_vsync <= 1'b1;
        cam2_vsync <= 1'b1;
        repeat (4) @(posedge clk);
        cam1_vsync <= 1'b0;
        cam2_vsync <= 1'b0;
        repeat (FRAME_CYCLES - 5) @(posedge clk);
    endtask

    // cam2's whole line trails cam1's by a random lag of 0 to 3 cycles.
    task automatic send_line(input int n1, input int n2);
        cam_byte_t   bytes_1[$];
        cam_byte_t   bytes_2[$];
        logic [15:0] val;
        int          lag;
        int          len;
        int          idx;
        for (int i = 0; i < n1; i++) begin
            take_bits(16, val);
            exp_q1.push_back(val);
            bytes_1.push_back(val[15:8]);
            bytes_1.push_back(val[7:0]);
        end
        for (int i = 0; i < n2; i++) begin
            take_bits(16, val);
            exp_q2.push_back(val);
            bytes_2.push_back(val[15:8]);
            bytes_2.push_back(val[7:0]);
        end
        take_bits(2, val);
        lag = int'(val[1:0]);
        len = (2 * n1 > lag + 2 * n2) ? 2 * n1 : lag + 2 * n2;
        for (int t = 0; t <= len; t++) begin
            idx = t - lag;
            @(posedge clk);
            cam1_href    <= (t < 2 * n1);
            cam1_byte_en <= (t < 2 * n1);
            cam1_data    <= (t < 2 * n1) ? bytes_1[t] : '0;
            cam2_href    <= (idx >= 0 && idx < 2 * n2);
            cam2_byte_en <= (idx >= 0 && idx < 2 * n2);
            cam2_data    <= (idx >= 0 && idx < 2 * n2) ? bytes_2[idx] : '0;
        end
        repeat (LINE_GAP) @(posedge clk);
    endtask

    task automatic send_matched_line();
        send_line(LINE_PIX, LINE_PIX);
        @(negedge clk);
        check_bit("comb_err after matched line", comb_err, 1'b0);
        check_bit("queues drained after line", exp_q1.size() == 0 && exp_q2.size() == 0, 1'b1);
    endtask

    initial begin
        rst_n        = 1'b0;
        cam1_vsync   = 1'b0;
        cam1_href    = 1'b0;
        cam1_byte_en = 1'b0;
        cam1_data    = '0;
        cam2_vsync   = 1'b0;
        cam2_href    = 1'b0;
        cam2_byte_en = 1'b0;
        cam2_data    = '0;
        lfsr_state   = LFSR_SEED;
        cycle_cnt    = 0;
        de_count     = 0;
        tick_count   = 0;
        hs_pulses    = 0;
        hs_age       = -1;
        since_reset  = 0;
        de_prev      = 1'b0;
        hs_prev      = 1'b0;
        vs_hist      = 2'b00;

        repeat (RST_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        repeat (5) @(posedge clk);

        start_frame();
        for (int i = 0; i < 6; i++) begin
            send_matched_line();
        end

        // a short line on cam2 leaves one cam1 pixel behind.
        send_line(LINE_PIX, LINE_PIX - 1);
        @(negedge clk);
        check_bit("comb_err after short line", comb_err, 1'b1);
        exp_q1.delete();
        exp_q2.delete();
        start_frame();
        @(negedge clk);
        check_bit("comb_err after frame start", comb_err, 1'b0);

        for (int i = 0; i < 2; i++) begin
            send_matched_line();
        end

        check_bit("hsync pulses seen", hs_pulses > 0, 1'b1);
        check_bit("pairs shown", de_count == NUM_PAIRS, 1'b1);
        check_bit("tick count", tick_count == NUM_PAIRS / TICK_PIXELS, 1'b1);
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule : aim_bot_tb

// File: aim_bot.f
hdl/aim_pkg.sv
hdl/cam_pixel_decode.sv
hdl/pixel_combine.sv
hdl/hdmi_out.sv
hdl/frame_tick.sv
hdl/aim_bot.sv
dv/aim_bot_assert.sv
dv/aim_bot_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the stereo pixel path testbench with Verilator and runs it.

set -u
cd "$(dirname "$0")"

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module aim_bot_tb -Mdir "$build_dir" -f aim_bot.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$build_dir/Vaim_bot_tb" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "ALL TESTS PASSED" "$log_file"; then
    echo "result: pass"
    exit 0
else
    echo "result: fail"
    exit 1
fi
